/* logic/dcache_pkg.sv */
package dcache_pkg;

  // Core and bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Byte offset bits below the word address
  localparam int WORD_OFF_W = $clog2(BE_W);

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    // Tag compare on the SRAM output
    ST_LOOKUP     = 3'd1,
    ST_FILL_WRITE = 3'd2,
    ST_MEM_READ   = 3'd3,
    // Eviction of a dirty line
    ST_MEM_WRITE  = 3'd4,
    ST_DONE       = 3'd5
  } cache_state_t;

endpackage

/* logic/cache_sram.sv */
`timescale 1ns/1ps

module cache_sram
  import dcache_pkg::*;
#(
  parameter int INDEX_W = 6,
  parameter int TAG_W   = 4
) (
  input  logic               clk_i,
  input  logic               wr_en_i,
  input  logic [INDEX_W-1:0] wr_idx_i,
  input  logic [TAG_W-1:0]   wr_tag_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  input  logic [BE_W-1:0]    wr_mask_i,
  input  logic               rd_en_i,
  input  logic [INDEX_W-1:0] rd_idx_i,
  output logic [TAG_W-1:0]   rd_tag_o,
  output logic [DATA_W-1:0]  rd_data_o
);

  localparam int LINES = 1 << INDEX_W;

  logic [TAG_W-1:0]  tag_mem  [LINES];
  logic [DATA_W-1:0] data_mem [LINES];

  // Write port, tag always written
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_idx_i] <= wr_tag_i;
      for (int b = 0; b < BE_W; b++) begin
        if (wr_mask_i[b]) begin
          data_mem[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // Read port, output holds between reads
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_tag_o  <= tag_mem[rd_idx_i];
      rd_data_o <= data_mem[rd_idx_i];
    end
  end

endmodule

/* logic/wb_mem_master.sv */
`timescale 1ns/1ps

module wb_mem_master
  import dcache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // Controller side
  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  logic [ADDR_W-1:0] mem_addr_i,
  input  logic [DATA_W-1:0] mem_wdata_i,
  output logic [DATA_W-1:0] mem_rdata_o,
  output logic              mem_done_o,
  // Wishbone classic
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic [BE_W-1:0]   wb_sel_o,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic              wb_ack_i
);

  logic start;
  logic finish;

  // No new cycle while the done pulse is out, request is still held then
  assign start  = !wb_cyc_o && mem_req_i && !mem_done_o;
  assign finish = wb_cyc_o && wb_ack_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_cyc_o   <= 1'b0;
      wb_stb_o   <= 1'b0;
      wb_we_o    <= 1'b0;
      mem_done_o <= 1'b0;
    end else begin
      mem_done_o <= finish;
      if (start) begin
        wb_cyc_o <= 1'b1;
        wb_stb_o <= 1'b1;
        wb_we_o  <= mem_we_i;
      end else if (finish) begin
        wb_cyc_o <= 1'b0;
        wb_stb_o <= 1'b0;
        wb_we_o  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      wb_adr_o <= mem_addr_i;
      wb_dat_o <= mem_wdata_i;
    end
    if (finish) begin
      mem_rdata_o <= wb_dat_i;
    end
  end

  // Whole words only
  assign wb_sel_o = {BE_W{1'b1}};

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
  import dcache_pkg::*;
#(
  parameter int INDEX_W = 6,
  parameter int TAG_W   = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Core side
  input  logic               req_i,
  input  logic               we_i,
  input  logic [ADDR_W-1:0]  addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  input  logic [BE_W-1:0]    be_i,
  output logic [DATA_W-1:0]  rdata_o,
  output logic               ack_o,
  output logic               stall_o,
  // SRAM side
  output logic               sram_wr_en_o,
  output logic [INDEX_W-1:0] sram_wr_idx_o,
  output logic [TAG_W-1:0]   sram_wr_tag_o,
  output logic [DATA_W-1:0]  sram_wr_data_o,
  output logic [BE_W-1:0]    sram_wr_mask_o,
  output logic               sram_rd_en_o,
  output logic [INDEX_W-1:0] sram_rd_idx_o,
  input  logic [TAG_W-1:0]   sram_rd_tag_i,
  input  logic [DATA_W-1:0]  sram_rd_data_i,
  // Bus master side
  output logic               mem_req_o,
  output logic               mem_we_o,
  output logic [ADDR_W-1:0]  mem_addr_o,
  output logic [DATA_W-1:0]  mem_wdata_o,
  input  logic [DATA_W-1:0]  mem_rdata_i,
  input  logic               mem_done_i
);

  localparam int LINES = 1 << INDEX_W;
  localparam int PAD_W = ADDR_W - TAG_W - INDEX_W - WORD_OFF_W;

  cache_state_t state_q;
  cache_state_t state_d;

  logic [LINES-1:0]   valid_q;
  logic [LINES-1:0]   dirty_q;
  logic               fill_from_mem_q;
  logic [DATA_W-1:0]  fill_data_q;
  logic [DATA_W-1:0]  rdata_q;

  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]   tag;
  logic               hit;
  logic               victim_dirty;
  logic               full_word;
  logic [ADDR_W-1:0]  fetch_addr;
  logic [ADDR_W-1:0]  evict_addr;

  // Core enabled bytes over a fetched word
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] mem_word,
    input logic [DATA_W-1:0] core_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] res;
    res = mem_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = core_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign idx = addr_i[WORD_OFF_W +: INDEX_W];
  assign tag = addr_i[WORD_OFF_W + INDEX_W +: TAG_W];

  assign hit          = valid_q[idx] && (sram_rd_tag_i == tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  assign full_word    = &be_i;

  // Bits above the tag are not part of the cached space
  assign fetch_addr = {{PAD_W{1'b0}}, tag, idx, {WORD_OFF_W{1'b0}}};
  assign evict_addr = {{PAD_W{1'b0}}, sram_rd_tag_i, idx, {WORD_OFF_W{1'b0}}};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          state_d = we_i ? ST_FILL_WRITE : ST_DONE;
        end else if (victim_dirty) begin
          state_d = ST_MEM_WRITE;
        end else if (we_i && full_word) begin
          state_d = ST_FILL_WRITE;
        end else begin
          state_d = ST_MEM_READ;
        end
      end
      ST_MEM_WRITE: begin
        if (mem_done_i) begin
          state_d = (we_i && full_word) ? ST_FILL_WRITE : ST_MEM_READ;
        end
      end
      ST_MEM_READ: begin
        if (mem_done_i) begin
          state_d = ST_FILL_WRITE;
        end
      end
      ST_FILL_WRITE: state_d = ST_DONE;
      ST_DONE:       state_d = ST_IDLE;
      default:       state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q         <= ST_IDLE;
      valid_q         <= '0;
      dirty_q         <= '0;
      fill_from_mem_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_MEM_READ && mem_done_i) begin
        fill_from_mem_q <= 1'b1;
      end
      if (state_q == ST_FILL_WRITE) begin
        valid_q[idx]    <= 1'b1;
        // Read fills are clean, any core write dirties the line
        dirty_q[idx]    <= we_i;
        fill_from_mem_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_LOOKUP && hit) begin
      rdata_q <= sram_rd_data_i;
    end
    if (state_q == ST_MEM_READ && mem_done_i) begin
      rdata_q     <= mem_rdata_i;
      fill_data_q <= we_i ? merge_bytes(mem_rdata_i, wdata_i, be_i) : mem_rdata_i;
    end
  end

  assign rdata_o = rdata_q;
  assign ack_o   = (state_q == ST_DONE);
  assign stall_o = (state_q != ST_IDLE) && (state_q != ST_DONE);

  // Read issued while idle so the compare follows directly
  assign sram_rd_en_o  = (state_q == ST_IDLE) && req_i;
  assign sram_rd_idx_o = idx;

  assign sram_wr_en_o   = (state_q == ST_FILL_WRITE);
  assign sram_wr_idx_o  = idx;
  assign sram_wr_tag_o  = tag;
  assign sram_wr_data_o = fill_from_mem_q ? fill_data_q : wdata_i;
  assign sram_wr_mask_o = fill_from_mem_q ? {BE_W{1'b1}} : be_i;

  // SRAM output still holds the victim during the eviction
  assign mem_req_o   = (state_q == ST_MEM_READ) || (state_q == ST_MEM_WRITE);
  assign mem_we_o    = (state_q == ST_MEM_WRITE);
  assign mem_addr_o  = (state_q == ST_MEM_WRITE) ? evict_addr : fetch_addr;
  assign mem_wdata_o = sram_rd_data_i;

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
#(
  parameter int INDEX_W = 6,
  parameter int TAG_W   = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Core port
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              ack_o,
  output logic              stall_o,
  // Wishbone to main memory
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic [BE_W-1:0]   wb_sel_o,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic              wb_ack_i
);

  logic               sram_wr_en;
  logic [INDEX_W-1:0] sram_wr_idx;
  logic [TAG_W-1:0]   sram_wr_tag;
  logic [DATA_W-1:0]  sram_wr_data;
  logic [BE_W-1:0]    sram_wr_mask;
  logic               sram_rd_en;
  logic [INDEX_W-1:0] sram_rd_idx;
  logic [TAG_W-1:0]   sram_rd_tag;
  logic [DATA_W-1:0]  sram_rd_data;

  logic               mem_req;
  logic               mem_we;
  logic [ADDR_W-1:0]  mem_addr;
  logic [DATA_W-1:0]  mem_wdata;
  logic [DATA_W-1:0]  mem_rdata;
  logic               mem_done;

  dcache_ctrl #(
    .INDEX_W (INDEX_W),
    .TAG_W   (TAG_W)
  ) dcache_ctrl_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .rdata_o        (rdata_o),
    .ack_o          (ack_o),
    .stall_o        (stall_o),
    .sram_wr_en_o   (sram_wr_en),
    .sram_wr_idx_o  (sram_wr_idx),
    .sram_wr_tag_o  (sram_wr_tag),
    .sram_wr_data_o (sram_wr_data),
    .sram_wr_mask_o (sram_wr_mask),
    .sram_rd_en_o   (sram_rd_en),
    .sram_rd_idx_o  (sram_rd_idx),
    .sram_rd_tag_i  (sram_rd_tag),
    .sram_rd_data_i (sram_rd_data),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_rdata_i    (mem_rdata),
    .mem_done_i     (mem_done)
  );

  cache_sram #(
    .INDEX_W (INDEX_W),
    .TAG_W   (TAG_W)
  ) cache_sram_i (
    .clk_i     (clk_i),
    .wr_en_i   (sram_wr_en),
    .wr_idx_i  (sram_wr_idx),
    .wr_tag_i  (sram_wr_tag),
    .wr_data_i (sram_wr_data),
    .wr_mask_i (sram_wr_mask),
    .rd_en_i   (sram_rd_en),
    .rd_idx_i  (sram_rd_idx),
    .rd_tag_o  (sram_rd_tag),
    .rd_data_o (sram_rd_data)
  );

  wb_mem_master wb_mem_master_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata),
    .mem_done_o  (mem_done),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_sel_o    (wb_sel_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i)
  );

endmodule

/* testbench/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model
  import dcache_pkg::*;
#(
  parameter int WORD_AW = 10,
  parameter int SEED    = 60
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [BE_W-1:0]   sel_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              ack_o
);

  localparam int WORDS = 1 << WORD_AW;

  logic [DATA_W-1:0]  mem [WORDS];
  // Completed transfers as {we, adr, data}
  logic [64:0]        xfer_log [$];
  integer             seed = SEED;
  logic               active;
  logic [1:0]         wait_left;
  logic [WORD_AW-1:0] word;

  assign word = adr_i[WORD_OFF_W +: WORD_AW];

  initial begin
    // Idle bus outputs before the first clock edge
    ack_o <= 1'b0;
    dat_o <= '0;
    for (int i = 0; i < WORDS; i++) begin
      // Odd multiplier gives every word address its own value
      mem[i] = DATA_W'(i) * 32'h9e37_79b1 ^ 32'h5a00_00c3;
    end
  end

  always @(posedge clk_i) begin : slave
    logic [31:0]       rnd;
    logic [1:0]        ws;
    logic [DATA_W-1:0] merged;
    ack_o <= 1'b0;
    if (rst_i) begin
      active    <= 1'b0;
      wait_left <= 2'd0;
    end else if (cyc_i && stb_i && !ack_o) begin
      rnd = $random(seed);
      // A fresh cycle draws 0 to 3 wait states
      ws = active ? wait_left : rnd[1:0];
      if (ws == 2'd0) begin
        active <= 1'b0;
        ack_o  <= 1'b1;
        if (we_i) begin
          merged = mem[word];
          for (int b = 0; b < BE_W; b++) begin
            if (sel_i[b]) begin
              merged[8*b +: 8] = dat_i[8*b +: 8];
            end
          end
          mem[word] <= merged;
          xfer_log.push_back({1'b1, adr_i, merged});
        end else begin
          dat_o <= mem[word];
          xfer_log.push_back({1'b0, adr_i, mem[word]});
        end
      end else begin
        active    <= 1'b1;
        wait_left <= ws - 2'd1;
      end
    end
  end

endmodule

/* testbench/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  localparam int INDEX_W = 6;
  localparam int TAG_W   = 4;
  localparam int WORDS   = 1 << (INDEX_W + TAG_W);
  localparam int SEED    = 60;
  localparam int TIMEOUT = 200;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              req_i;
  logic              we_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] wdata_i;
  logic [BE_W-1:0]   be_i;
  logic [DATA_W-1:0] rdata_o;
  logic              ack_o;
  logic              stall_o;
  logic              wb_cyc_o;
  logic              wb_stb_o;
  logic              wb_we_o;
  logic [ADDR_W-1:0] wb_adr_o;
  logic [DATA_W-1:0] wb_dat_o;
  logic [BE_W-1:0]   wb_sel_o;
  logic [DATA_W-1:0] wb_dat_i;
  logic              wb_ack_i;

  // Architectural memory contents as the core sees them
  logic [DATA_W-1:0] ref_mem [WORDS];
  integer            seed = SEED;
  int                errors = 0;
  int                test_errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  bit                timed_out = 1'b0;

  dcache_top #(
    .INDEX_W (INDEX_W),
    .TAG_W   (TAG_W)
  ) dcache_top_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .rdata_o  (rdata_o),
    .ack_o    (ack_o),
    .stall_o  (stall_o),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

  wb_mem_model #(
    .WORD_AW (INDEX_W + TAG_W),
    .SEED    (SEED)
  ) mem_model_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (wb_cyc_o),
    .stb_i (wb_stb_o),
    .we_i  (wb_we_o),
    .adr_i (wb_adr_o),
    .dat_i (wb_dat_o),
    .sel_i (wb_sel_o),
    .dat_o (wb_dat_i),
    .ack_o (wb_ack_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [DATA_W-1:0] init_word(input int w);
    return DATA_W'(w) * 32'h9e37_79b1 ^ 32'h5a00_00c3;
  endfunction

  function automatic logic [ADDR_W-1:0] line_addr(input int tag, input int idx);
    return ADDR_W'(((tag << INDEX_W) + idx) << WORD_OFF_W);
  endfunction

  task automatic note_mismatch(input string name, input logic [31:0] exp,
      input logic [31:0] got);
    errors++;
    test_errors++;
    $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
  endtask

  task automatic flag_problem(input string msg);
    errors++;
    test_errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic store_ref(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
      input logic [BE_W-1:0] be);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // Entered on a falling edge
  // Counts falling edges up to the one that sees ack_o in waited
  task automatic core_access(input logic we, input logic [ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
      output logic [DATA_W-1:0] data, output int waited);
    bit acked;
    acked = 1'b0;
    waited = 0;
    data = '0;
    if (!timed_out) begin
      req_i   = 1'b1;
      we_i    = we;
      addr_i  = addr;
      wdata_i = wdata;
      be_i    = be;
      while (!acked && waited < TIMEOUT) begin
        @(negedge clk_i);
        waited++;
        if (wb_cyc_o && wb_sel_o !== {BE_W{1'b1}}) begin
          note_mismatch("wb_sel_o", 32'({BE_W{1'b1}}), 32'(wb_sel_o));
        end
        if (ack_o) begin
          acked = 1'b1;
          data = rdata_o;
          if (stall_o) flag_problem("stall_o is high together with ack_o");
        end else if (!stall_o) begin
          flag_problem("stall_o is low while a request is pending");
        end
      end
      req_i = 1'b0;
      if (acked) begin
        @(negedge clk_i);
      end else begin
        timed_out = 1'b1;
        flag_problem($sformatf("no ack_o within %0d cycles, controller in state %s",
          TIMEOUT, dcache_top_i.dcache_ctrl_i.state_q.name()));
      end
    end
  endtask

  task automatic expect_transfer(input int pos, input logic we,
      input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    logic [64:0] entry;
    if (pos >= mem_model_i.xfer_log.size()) begin
      flag_problem($sformatf("bus transfer %0d never took place", pos));
    end else begin
      entry = mem_model_i.xfer_log[pos];
      if (entry[64] !== we) flag_problem(we ? "bus read seen, write expected" :
        "bus write seen, read expected");
      if (entry[63:32] !== adr) note_mismatch("wb_adr_o", adr, entry[63:32]);
      if (entry[31:0] !== dat) note_mismatch(we ? "wb_dat_o" : "wb_dat_i", dat, entry[31:0]);
    end
  endtask

  task automatic after_reset_reads();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    int                waited;
    int                base;
    if (ack_o !== 1'b0) note_mismatch("ack_o", 0, 32'(ack_o));
    if (stall_o !== 1'b0) note_mismatch("stall_o", 0, 32'(stall_o));
    if (wb_cyc_o !== 1'b0) note_mismatch("wb_cyc_o", 0, 32'(wb_cyc_o));
    if (wb_stb_o !== 1'b0) note_mismatch("wb_stb_o", 0, 32'(wb_stb_o));
    if (wb_we_o !== 1'b0) note_mismatch("wb_we_o", 0, 32'(wb_we_o));
    for (int i = 0; i < 8; i++) begin
      addr = line_addr(1, i);
      base = mem_model_i.xfer_log.size();
      core_access(1'b0, addr, '0, 4'hf, data, waited);
      if (data !== ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]]) begin
        note_mismatch("rdata_o", ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]], data);
      end
      if (mem_model_i.xfer_log.size() != base + 1) begin
        note_mismatch("bus transfer count", base + 1, mem_model_i.xfer_log.size());
      end
      expect_transfer(base, 1'b0, addr, ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]]);
    end
  endtask

  task automatic cached_rereads();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    int                waited;
    int                base;
    for (int i = 0; i < 8; i++) begin
      addr = line_addr(1, i);
      base = mem_model_i.xfer_log.size();
      core_access(1'b0, addr, '0, 4'hf, data, waited);
      if (data !== ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]]) begin
        note_mismatch("rdata_o", ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]], data);
      end
      if (waited != 2) note_mismatch("read hit latency", 2, waited);
      if (mem_model_i.xfer_log.size() != base) begin
        note_mismatch("bus transfer count", base, mem_model_i.xfer_log.size());
      end
    end
  endtask

  task automatic random_traffic();
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp_word;
    int                waited;
    for (int i = 0; i < 300 && !timed_out; i++) begin
      rnd = $random(seed);
      // Four tags over eight lines
      addr = line_addr(int'(rnd[1:0]), int'(rnd[4:2]));
      be = rnd[8] ? 4'hf : rnd[12:9];
      if (be == 4'h0) be = 4'hf;
      wdata = $random(seed);
      if (rnd[5]) begin
        core_access(1'b1, addr, wdata, be, data, waited);
        store_ref(addr, wdata, be);
      end else begin
        exp_word = ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]];
        core_access(1'b0, addr, '0, 4'hf, data, waited);
        if (data !== exp_word) note_mismatch("rdata_o", exp_word, data);
      end
    end
  endtask

  task automatic dirty_eviction();
    logic [ADDR_W-1:0] old_addr;
    logic [ADDR_W-1:0] new_addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] data;
    int                waited;
    int                base;
    old_addr = line_addr(1, 20);
    new_addr = line_addr(2, 20);
    wdata = $random(seed);
    base = mem_model_i.xfer_log.size();
    core_access(1'b1, old_addr, wdata, 4'hf, data, waited);
    store_ref(old_addr, wdata, 4'hf);
    if (mem_model_i.xfer_log.size() != base) begin
      note_mismatch("bus transfer count", base, mem_model_i.xfer_log.size());
    end
    base = mem_model_i.xfer_log.size();
    core_access(1'b0, new_addr, '0, 4'hf, data, waited);
    if (data !== ref_mem[new_addr[WORD_OFF_W +: INDEX_W + TAG_W]]) begin
      note_mismatch("rdata_o", ref_mem[new_addr[WORD_OFF_W +: INDEX_W + TAG_W]], data);
    end
    if (mem_model_i.xfer_log.size() != base + 2) begin
      note_mismatch("bus transfer count", base + 2, mem_model_i.xfer_log.size());
    end
    expect_transfer(base, 1'b1, old_addr, wdata);
    expect_transfer(base + 1, 1'b0, new_addr, ref_mem[new_addr[WORD_OFF_W +: INDEX_W + TAG_W]]);
  endtask

  task automatic hit_timing_and_clean_evict();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] data;
    int                waited;
    int                base;
    addr = line_addr(0, 21);
    wdata = $random(seed);
    core_access(1'b0, addr, '0, 4'hf, data, waited);
    base = mem_model_i.xfer_log.size();
    core_access(1'b1, addr, wdata, 4'hf, data, waited);
    store_ref(addr, wdata, 4'hf);
    if (waited != 3) note_mismatch("write hit latency", 3, waited);
    core_access(1'b0, addr, '0, 4'hf, data, waited);
    if (data !== wdata) note_mismatch("rdata_o", wdata, data);
    if (waited != 2) note_mismatch("read hit latency", 2, waited);
    if (mem_model_i.xfer_log.size() != base) begin
      note_mismatch("bus transfer count", base, mem_model_i.xfer_log.size());
    end
    // Clean victim on line 22
    core_access(1'b0, line_addr(0, 22), '0, 4'hf, data, waited);
    addr = line_addr(3, 22);
    base = mem_model_i.xfer_log.size();
    core_access(1'b0, addr, '0, 4'hf, data, waited);
    if (data !== ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]]) begin
      note_mismatch("rdata_o", ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]], data);
    end
    if (mem_model_i.xfer_log.size() != base + 1) begin
      note_mismatch("bus transfer count", base + 1, mem_model_i.xfer_log.size());
    end
    expect_transfer(base, 1'b0, addr, ref_mem[addr[WORD_OFF_W +: INDEX_W + TAG_W]]);
  endtask

  initial begin
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    for (int w = 0; w < WORDS; w++) begin
      ref_mem[w] = init_word(w);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    after_reset_reads();
    close_test("after reset");
    if (!timed_out) begin
      cached_rereads();
      close_test("cached rereads");
    end
    if (!timed_out) begin
      random_traffic();
      close_test("random traffic");
    end
    if (!timed_out) begin
      dirty_eviction();
      close_test("dirty eviction");
    end
    if (!timed_out) begin
      hit_timing_and_clean_evict();
      close_test("hit timing and clean eviction");
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
      tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
logic/dcache_pkg.sv
logic/cache_sram.sv
logic/wb_mem_master.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/wb_mem_model.sv
testbench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_dcache -f project.f -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

exit 0
